// ==== source/avalon_mem_pkg.sv ====
// ==========================================================================
// Shared widths, depths and stage counts for the local memory path.
// REQ_FIFO_DEPTH must be a power of two so the queue pointers wrap freely.
// Burst counts run from 1 to MAX_BURST and a count of zero is not legal.
// ==========================================================================

`default_nettype none

package avalon_mem_pkg;

    // Word address, data and byte enable widths
    localparam int MEM_ADDR_W = 10;
    localparam int MEM_DATA_W = 64;
    localparam int MEM_BE_W = MEM_DATA_W / 8;
    localparam int MEM_WORDS = 1024;

    // Longest burst and the count width that can hold it
    localparam int MAX_BURST = 4;
    localparam int MEM_BURST_W = $clog2(MAX_BURST + 1);

    // Default register stage counts between the AFU and the FIU
    localparam int N_REG_STAGES = 2;
    localparam int N_WAITREQUEST_STAGES = 2;

    // Request queue sizing
    localparam int REQ_FIFO_DEPTH = 16;
    localparam int REQ_FIFO_PTR_W = $clog2(REQ_FIFO_DEPTH);
    localparam int REQ_FIFO_CNT_W = $clog2(REQ_FIFO_DEPTH + 1);

    // Requests that may still land after the queue raises waitrequest
    localparam int REQ_FIFO_SLACK = N_REG_STAGES + N_WAITREQUEST_STAGES + 1;

    typedef logic [MEM_ADDR_W-1:0]  mem_addr_t;
    typedef logic [MEM_DATA_W-1:0]  mem_data_t;
    typedef logic [MEM_BE_W-1:0]    mem_be_t;
    typedef logic [MEM_BURST_W-1:0] mem_burst_t;

    // Burst engine states
    typedef enum logic [1:0] {
        ENG_IDLE,
        ENG_WRITE_BURST,
        ENG_READ_BURST
    } eng_state_t;

endpackage

`default_nettype wire

// ==== source/avalon_mem_reg_stage.sv ====
// ==========================================================================
// Avalon-MM register stage between an AFU and the FIU memory side.
// Waitrequest behaves as almost-full: the FIU side must still accept
// N_REG_STAGES + N_WAITREQUEST_STAGES requests after raising it.
// N_REG_STAGES and N_WAITREQUEST_STAGES must both be at least 1.
// ==========================================================================

`timescale 1ns/1ns
`default_nettype none

module avalon_mem_reg_stage
    import avalon_mem_pkg::*;
#(
    parameter int N_REG_STAGES = avalon_mem_pkg::N_REG_STAGES,
    parameter int N_WAITREQUEST_STAGES = avalon_mem_pkg::N_WAITREQUEST_STAGES
)
(
    input  wire logic       mem_fiu,
    input  wire logic       rst_n,

    // AFU side
    input  wire mem_addr_t  afu_address,
    input  wire mem_burst_t afu_burstcount,
    input  wire mem_data_t  afu_writedata,
    input  wire mem_be_t    afu_byteenable,
    input  wire logic       afu_read,
    input  wire logic       afu_write,
    output logic            afu_waitrequest,
    output mem_data_t       afu_readdata,
    output logic            afu_readdatavalid,

    // FIU side
    output mem_addr_t       fiu_address,
    output mem_burst_t      fiu_burstcount,
    output mem_data_t       fiu_writedata,
    output mem_be_t         fiu_byteenable,
    output logic            fiu_read,
    output logic            fiu_write,
    input  wire logic       fiu_waitrequest,
    input  wire mem_data_t  fiu_readdata,
    input  wire logic       fiu_readdatavalid
);

    // Entry 0 of each request array is the AFU input, the last entry feeds the FIU
    mem_addr_t  req_address    [N_REG_STAGES+1];
    mem_burst_t req_burstcount [N_REG_STAGES+1];
    mem_data_t  req_writedata  [N_REG_STAGES+1];
    mem_be_t    req_byteenable [N_REG_STAGES+1];
    logic       req_read       [N_REG_STAGES+1];
    logic       req_write      [N_REG_STAGES+1];

    // Entry 0 of each response array is the FIU input, the last one feeds the AFU
    mem_data_t  rsp_readdata   [N_REG_STAGES+1];
    logic       rsp_valid      [N_REG_STAGES+1];

    // Bit 0 takes the FIU waitrequest, the top bit is what the AFU sees
    logic [N_WAITREQUEST_STAGES-1:0] wait_pipe;

    // A strobe only enters the pipe if the AFU could see waitrequest low
    assign req_address[0]    = afu_address;
    assign req_burstcount[0] = afu_burstcount;
    assign req_writedata[0]  = afu_writedata;
    assign req_byteenable[0] = afu_byteenable;
    assign req_read[0]       = afu_read && !afu_waitrequest;
    assign req_write[0]      = afu_write && !afu_waitrequest;

    assign rsp_readdata[0] = fiu_readdata;
    assign rsp_valid[0]    = fiu_readdatavalid;

    genvar s;
    generate
        for (s = 1; s <= N_REG_STAGES; s = s + 1)
        begin : g_stage
            // Strobes are cleared on reset so no stale request escapes
            always_ff @(posedge mem_fiu or negedge rst_n)
            begin
                if (!rst_n)
                begin
                    req_read[s]  <= 1'b0;
                    req_write[s] <= 1'b0;
                    rsp_valid[s] <= 1'b0;
                end
                else
                begin
                    req_read[s]  <= req_read[s-1];
                    req_write[s] <= req_write[s-1];
                    rsp_valid[s] <= rsp_valid[s-1];
                end
            end

            // Payload only has meaning alongside a strobe
            always_ff @(posedge mem_fiu)
            begin
                req_address[s]    <= req_address[s-1];
                req_burstcount[s] <= req_burstcount[s-1];
                req_writedata[s]  <= req_writedata[s-1];
                req_byteenable[s] <= req_byteenable[s-1];
                rsp_readdata[s]   <= rsp_readdata[s-1];
            end
        end
    endgenerate

    // Waitrequest delay line, held high out of reset
    always_ff @(posedge mem_fiu or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wait_pipe <= '1;
        end
        else
        begin
            wait_pipe[0] <= fiu_waitrequest;
            for (int i = 1; i < N_WAITREQUEST_STAGES; i++)
            begin
                wait_pipe[i] <= wait_pipe[i-1];
            end
        end
    end

    assign afu_waitrequest   = wait_pipe[N_WAITREQUEST_STAGES-1];
    assign afu_readdata      = rsp_readdata[N_REG_STAGES];
    assign afu_readdatavalid = rsp_valid[N_REG_STAGES];

    assign fiu_address    = req_address[N_REG_STAGES];
    assign fiu_burstcount = req_burstcount[N_REG_STAGES];
    assign fiu_writedata  = req_writedata[N_REG_STAGES];
    assign fiu_byteenable = req_byteenable[N_REG_STAGES];
    assign fiu_read       = req_read[N_REG_STAGES];
    assign fiu_write      = req_write[N_REG_STAGES];

endmodule

`default_nettype wire

// ==== source/mem_req_fifo.sv ====
// ==========================================================================
// Request queue in front of the burst engine.
// Every strobed entry is stored, there is no overflow check, so the
// REQ_FIFO_SLACK margin on waitrequest must cover all requests in flight.
// ==========================================================================

`timescale 1ns/1ns
`default_nettype none

module mem_req_fifo
    import avalon_mem_pkg::*;
(
    input  wire logic       mem_fiu,
    input  wire logic       rst_n,

    // Push side from the register stage
    input  wire mem_addr_t  in_address,
    input  wire mem_burst_t in_burstcount,
    input  wire mem_data_t  in_writedata,
    input  wire mem_be_t    in_byteenable,
    input  wire logic       in_read,
    input  wire logic       in_write,
    output logic            fifo_waitrequest,

    // Head of the queue toward the engine
    output logic            req_valid,
    output mem_addr_t       req_address,
    output mem_burst_t      req_burstcount,
    output mem_data_t       req_writedata,
    output mem_be_t         req_byteenable,
    output logic            req_is_write,
    input  wire logic       req_pop
);

    mem_addr_t  q_address    [REQ_FIFO_DEPTH];
    mem_burst_t q_burstcount [REQ_FIFO_DEPTH];
    mem_data_t  q_writedata  [REQ_FIFO_DEPTH];
    mem_be_t    q_byteenable [REQ_FIFO_DEPTH];
    logic       q_is_write   [REQ_FIFO_DEPTH];

    logic [REQ_FIFO_PTR_W-1:0] wr_ptr;
    logic [REQ_FIFO_PTR_W-1:0] rd_ptr;
    logic [REQ_FIFO_CNT_W-1:0] count;
    logic [REQ_FIFO_CNT_W-1:0] count_next;
    logic                      push;
    logic                      pop;

    assign push = in_read || in_write;
    assign pop  = req_pop && req_valid;

    always_comb
    begin
        count_next = count + REQ_FIFO_CNT_W'(push) - REQ_FIFO_CNT_W'(pop);
    end

    // Pointers, fill level and the almost-full flag
    always_ff @(posedge mem_fiu or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr           <= '0;
            rd_ptr           <= '0;
            count            <= '0;
            fifo_waitrequest <= 1'b1;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count_next;
            // Raised once fewer than REQ_FIFO_SLACK entries remain free
            fifo_waitrequest <= (REQ_FIFO_DEPTH - int'(count_next)) < REQ_FIFO_SLACK;
        end
    end

    // Entry storage
    always_ff @(posedge mem_fiu)
    begin
        if (push)
        begin
            q_address[wr_ptr]    <= in_address;
            q_burstcount[wr_ptr] <= in_burstcount;
            q_writedata[wr_ptr]  <= in_writedata;
            q_byteenable[wr_ptr] <= in_byteenable;
            q_is_write[wr_ptr]   <= in_write;
        end
    end

    assign req_valid      = (count != '0);
    assign req_address    = q_address[rd_ptr];
    assign req_burstcount = q_burstcount[rd_ptr];
    assign req_writedata  = q_writedata[rd_ptr];
    assign req_byteenable = q_byteenable[rd_ptr];
    assign req_is_write   = q_is_write[rd_ptr];

endmodule

`default_nettype wire

// ==== source/mem_burst_engine.sv ====
// ==========================================================================
// Burst engine between the request queue and the local RAM.
// A write burst occupies one queue entry per beat, a read burst only one.
// Responses leave two cycles after each RAM read address and cannot stall.
// ==========================================================================

`timescale 1ns/1ns
`default_nettype none

module mem_burst_engine
    import avalon_mem_pkg::*;
(
    input  wire logic       mem_fiu,
    input  wire logic       rst_n,

    // Queue head
    input  wire logic       req_valid,
    input  wire mem_addr_t  req_address,
    input  wire mem_burst_t req_burstcount,
    input  wire mem_data_t  req_writedata,
    input  wire mem_be_t    req_byteenable,
    input  wire logic       req_is_write,
    output logic            req_pop,

    // RAM port
    output logic            ram_we,
    output mem_be_t         ram_be,
    output mem_addr_t       ram_addr,
    output mem_data_t       ram_wdata,
    input  wire mem_data_t  ram_rdata,

    // Read responses
    output logic            rsp_valid,
    output mem_data_t       rsp_data
);

    eng_state_t state;

    // Burst base address, index of the next beat and beats still to run
    mem_addr_t  base_addr;
    mem_burst_t beat_idx;
    mem_burst_t beats_left;

    // A RAM read goes out this cycle, and its delayed copy lines up with ram_rdata
    logic       rd_issue;
    logic       rd_issue_d;

    always_comb
    begin
        req_pop   = 1'b0;
        ram_we    = 1'b0;
        rd_issue  = 1'b0;
        ram_be    = req_byteenable;
        ram_wdata = req_writedata;
        ram_addr  = base_addr + mem_addr_t'(beat_idx);

        case (state)
            ENG_IDLE:
            begin
                // The first beat of any request uses the address from the head
                ram_addr = req_address;
                if (req_valid)
                begin
                    req_pop  = 1'b1;
                    ram_we   = req_is_write;
                    rd_issue = !req_is_write;
                end
            end
            ENG_WRITE_BURST:
            begin
                // Later write beats wait for their data to reach the head
                if (req_valid)
                begin
                    req_pop = 1'b1;
                    ram_we  = 1'b1;
                end
            end
            ENG_READ_BURST:
            begin
                // The read was popped already, so the queue is left alone
                rd_issue = 1'b1;
            end
            default:
            begin
                ram_we = 1'b0;
            end
        endcase
    end

    always_ff @(posedge mem_fiu or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= ENG_IDLE;
            beat_idx   <= '0;
            beats_left <= '0;
            rd_issue_d <= 1'b0;
            rsp_valid  <= 1'b0;
        end
        else
        begin
            rd_issue_d <= rd_issue;
            rsp_valid  <= rd_issue_d;

            case (state)
                ENG_IDLE:
                begin
                    if (req_valid)
                    begin
                        beat_idx   <= mem_burst_t'(1);
                        beats_left <= req_burstcount - 1'b1;
                        // Single-beat requests finish in this cycle
                        if (req_burstcount > mem_burst_t'(1))
                        begin
                            state <= req_is_write ? ENG_WRITE_BURST : ENG_READ_BURST;
                        end
                    end
                end
                ENG_WRITE_BURST,
                ENG_READ_BURST:
                begin
                    if (req_valid || state == ENG_READ_BURST)
                    begin
                        beat_idx   <= beat_idx + 1'b1;
                        beats_left <= beats_left - 1'b1;
                        if (beats_left == mem_burst_t'(1))
                        begin
                            state <= ENG_IDLE;
                        end
                    end
                end
                default:
                begin
                    state <= ENG_IDLE;
                end
            endcase
        end
    end

    // Base is captured with the first beat, read data is retimed once more
    always_ff @(posedge mem_fiu)
    begin
        if (state == ENG_IDLE && req_valid)
        begin
            base_addr <= req_address;
        end
        rsp_data <= ram_rdata;
    end

endmodule

`default_nettype wire

// ==== source/mem_bank_ram.sv ====
// ==========================================================================
// Single-port word RAM with byte enables and a registered read.
// A read of the word being written returns the old contents.
// Contents are undefined until written.
// ==========================================================================

`timescale 1ns/1ns
`default_nettype none

module mem_bank_ram
    import avalon_mem_pkg::*;
(
    input  wire logic      mem_fiu,
    input  wire logic      we,
    input  wire mem_be_t   be,
    input  wire mem_addr_t addr,
    input  wire mem_data_t wdata,
    output mem_data_t      rdata
);

    mem_data_t mem [MEM_WORDS];

    always_ff @(posedge mem_fiu)
    begin
        if (we)
        begin
            // Only the enabled bytes of the word change
            for (int b = 0; b < MEM_BE_W; b++)
            begin
                if (be[b])
                begin
                    mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
        // Data shows up one cycle after the address
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

// ==== source/local_mem_subsystem.sv ====
// ==========================================================================
// Local memory reached from the AFU through the Avalon-MM register stage.
// Stage counts come from the package defaults, and back-pressure only
// comes from the request queue fill level.
// ==========================================================================

`timescale 1ns/1ns
`default_nettype none

module local_mem_subsystem
    import avalon_mem_pkg::*;
(
    input  wire logic       mem_fiu,
    input  wire logic       rst_n,

    input  wire mem_addr_t  afu_address,
    input  wire mem_burst_t afu_burstcount,
    input  wire mem_data_t  afu_writedata,
    input  wire mem_be_t    afu_byteenable,
    input  wire logic       afu_read,
    input  wire logic       afu_write,
    output logic            afu_waitrequest,
    output mem_data_t       afu_readdata,
    output logic            afu_readdatavalid
);

    // Register stage to request queue
    mem_addr_t  fiu_address;
    mem_burst_t fiu_burstcount;
    mem_data_t  fiu_writedata;
    mem_be_t    fiu_byteenable;
    logic       fiu_read;
    logic       fiu_write;
    logic       fifo_waitrequest;

    // Queue head to engine
    logic       req_valid;
    mem_addr_t  req_address;
    mem_burst_t req_burstcount;
    mem_data_t  req_writedata;
    mem_be_t    req_byteenable;
    logic       req_is_write;
    logic       req_pop;

    // Engine to RAM and the response path
    logic       ram_we;
    mem_be_t    ram_be;
    mem_addr_t  ram_addr;
    mem_data_t  ram_wdata;
    mem_data_t  ram_rdata;
    logic       rsp_valid;
    mem_data_t  rsp_data;

    avalon_mem_reg_stage #(
        .N_REG_STAGES         (N_REG_STAGES),
        .N_WAITREQUEST_STAGES (N_WAITREQUEST_STAGES)
    ) u_reg_stage (
        .mem_fiu           (mem_fiu),
        .rst_n             (rst_n),
        .afu_address       (afu_address),
        .afu_burstcount    (afu_burstcount),
        .afu_writedata     (afu_writedata),
        .afu_byteenable    (afu_byteenable),
        .afu_read          (afu_read),
        .afu_write         (afu_write),
        .afu_waitrequest   (afu_waitrequest),
        .afu_readdata      (afu_readdata),
        .afu_readdatavalid (afu_readdatavalid),
        .fiu_address       (fiu_address),
        .fiu_burstcount    (fiu_burstcount),
        .fiu_writedata     (fiu_writedata),
        .fiu_byteenable    (fiu_byteenable),
        .fiu_read          (fiu_read),
        .fiu_write         (fiu_write),
        .fiu_waitrequest   (fifo_waitrequest),
        .fiu_readdata      (rsp_data),
        .fiu_readdatavalid (rsp_valid)
    );

    mem_req_fifo u_req_fifo (
        .mem_fiu          (mem_fiu),
        .rst_n            (rst_n),
        .in_address       (fiu_address),
        .in_burstcount    (fiu_burstcount),
        .in_writedata     (fiu_writedata),
        .in_byteenable    (fiu_byteenable),
        .in_read          (fiu_read),
        .in_write         (fiu_write),
        .fifo_waitrequest (fifo_waitrequest),
        .req_valid        (req_valid),
        .req_address      (req_address),
        .req_burstcount   (req_burstcount),
        .req_writedata    (req_writedata),
        .req_byteenable   (req_byteenable),
        .req_is_write     (req_is_write),
        .req_pop          (req_pop)
    );

    mem_burst_engine u_engine (
        .mem_fiu        (mem_fiu),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req_address    (req_address),
        .req_burstcount (req_burstcount),
        .req_writedata  (req_writedata),
        .req_byteenable (req_byteenable),
        .req_is_write   (req_is_write),
        .req_pop        (req_pop),
        .ram_we         (ram_we),
        .ram_be         (ram_be),
        .ram_addr       (ram_addr),
        .ram_wdata      (ram_wdata),
        .ram_rdata      (ram_rdata),
        .rsp_valid      (rsp_valid),
        .rsp_data       (rsp_data)
    );

    mem_bank_ram u_ram (
        .mem_fiu (mem_fiu),
        .we      (ram_we),
        .be      (ram_be),
        .addr    (ram_addr),
        .wdata   (ram_wdata),
        .rdata   (ram_rdata)
    );

endmodule

`default_nettype wire

// ==== sim/tb_local_mem_subsystem.sv ====
// ==========================================================================
// Testbench for the local memory subsystem behind the Avalon-MM stage.
// Inputs change on the falling clock edge and outputs are sampled there too.
// Random traffic stays inside a 64-word window that is written in full
// before any random read, so no read returns uninitialized RAM contents.
// The first failed check stops the run.
// ==========================================================================

`timescale 1ns/1ns
`default_nettype none

module tb_local_mem_subsystem
    import avalon_mem_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 10;
    localparam logic [31:0] LCG_SEED = 32'd17;
    localparam int N_RANDOM_OPS = 200;
    // Directed writes, reads, the window fill and the back-pressure run
    localparam int N_DIRECTED_OPS = 40;
    localparam mem_addr_t RAND_BASE = 10'h100;
    localparam int RAND_WORDS = 64;
    localparam int RELEASE_LIMIT = N_WAITREQUEST_STAGES + 4;
    // Cycles for a full queue and both stage pipes to return every read beat
    localparam int DRAIN_LIMIT = (REQ_FIFO_DEPTH + N_REG_STAGES + 2) * MAX_BURST
                                 + 4 * (N_REG_STAGES + N_WAITREQUEST_STAGES);
    // Worst case cycles that one request may need to get through
    localparam int OP_CYCLES = MAX_BURST + REQ_FIFO_DEPTH
                               + 2 * (N_REG_STAGES + N_WAITREQUEST_STAGES);
    localparam int TIMEOUT_NS = (N_RANDOM_OPS + N_DIRECTED_OPS) * OP_CYCLES * CLK_PERIOD
                                + (RESET_CYCLES + 1) * CLK_PERIOD;

    logic       mem_fiu;
    logic       rst_n;
    mem_addr_t  afu_address;
    mem_burst_t afu_burstcount;
    mem_data_t  afu_writedata;
    mem_be_t    afu_byteenable;
    logic       afu_read;
    logic       afu_write;
    logic       afu_waitrequest;
    mem_data_t  afu_readdata;
    logic       afu_readdatavalid;

    // Reference memory and the words that outstanding reads must return
    mem_data_t   ref_mem [MEM_WORDS];
    mem_data_t   exp_q [$];
    mem_data_t   expected_word;
    logic [31:0] lcg_state;
    int          exp_beats;
    int          rdv_count;
    int          stall_cycles;
    bit          run_active;

    local_mem_subsystem u_dut (
        .mem_fiu           (mem_fiu),
        .rst_n             (rst_n),
        .afu_address       (afu_address),
        .afu_burstcount    (afu_burstcount),
        .afu_writedata     (afu_writedata),
        .afu_byteenable    (afu_byteenable),
        .afu_read          (afu_read),
        .afu_write         (afu_write),
        .afu_waitrequest   (afu_waitrequest),
        .afu_readdata      (afu_readdata),
        .afu_readdatavalid (afu_readdatavalid)
    );

    initial
    begin
        mem_fiu = 1'b1;
        forever #(CLK_PERIOD / 2) mem_fiu = ~mem_fiu;
    end

    // Stops the run with the reason and the fail message
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic value_error(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        $display("ERR t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
        abort_run("Stopped at the first wrong value");
    endtask

    // Plain LCG whose upper bits have the longest period
    function automatic logic [15:0] next_rand16();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    function automatic mem_data_t rand_word();
        mem_data_t w;
        for (int i = 0; i < 4; i++)
        begin
            w[i*16 +: 16] = next_rand16();
        end
        return w;
    endfunction

    function automatic int rand_below(input int n);
        return int'(next_rand16()) % n;
    endfunction

    // Only the enabled bytes of the reference word change
    task automatic model_write(input mem_addr_t a, input mem_data_t data, input mem_be_t be);
        for (int b = 0; b < MEM_BE_W; b++)
        begin
            if (be[b])
            begin
                ref_mem[a][b*8 +: 8] = data[b*8 +: 8];
            end
        end
    endtask

    // Outputs that must hold while reset or the waitrequest delay is active
    task automatic check_idle_outputs();
        assert (afu_waitrequest === 1'b1)
        else value_error("afu_waitrequest", 64'(1), 64'(afu_waitrequest));
        assert (afu_readdatavalid === 1'b0)
        else value_error("afu_readdatavalid", 64'(0), 64'(afu_readdatavalid));
    endtask

    // Holds the request until waitrequest is low, so it is taken at the next rising edge
    task automatic drive_req(input logic rd, input logic wr, input mem_addr_t addr,
                             input mem_burst_t bc, input mem_data_t data, input mem_be_t be);
        @(negedge mem_fiu);
        afu_read       = rd;
        afu_write      = wr;
        afu_address    = addr;
        afu_burstcount = bc;
        afu_writedata  = data;
        afu_byteenable = be;
        while (afu_waitrequest)
        begin
            stall_cycles++;
            @(negedge mem_fiu);
        end
    endtask

    task automatic write_beat(input mem_addr_t base, input mem_burst_t bc, input int idx,
                              input mem_data_t data, input mem_be_t be);
        mem_addr_t bus_addr;
        // Later beats carry a junk address since only the first one counts
        bus_addr = (idx == 0) ? base : mem_addr_t'(next_rand16());
        drive_req(1'b0, 1'b1, bus_addr, bc, data, be);
        model_write(base + mem_addr_t'(idx), data, be);
    endtask

    task automatic write_burst(input mem_addr_t base, input int beats, input bit full_be);
        mem_be_t be;
        for (int i = 0; i < beats; i++)
        begin
            be = full_be ? '1 : mem_be_t'(next_rand16());
            write_beat(base, mem_burst_t'(beats), i, rand_word(), be);
        end
    endtask

    // Expected words are taken when the read is accepted, in request order
    task automatic read_burst(input mem_addr_t base, input int beats);
        drive_req(1'b1, 1'b0, base, mem_burst_t'(beats), rand_word(), '1);
        for (int i = 0; i < beats; i++)
        begin
            exp_q.push_back(ref_mem[base + mem_addr_t'(i)]);
        end
        exp_beats += beats;
    endtask

    task automatic release_bus();
        @(negedge mem_fiu);
        afu_read  = 1'b0;
        afu_write = 1'b0;
    endtask

    // Every requested read beat must come back within the drain time
    task automatic wait_reads_done();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT)
        begin
            @(negedge mem_fiu);
            waited++;
        end
        assert (rdv_count == exp_beats)
        else value_error("afu_readdatavalid count", 64'(exp_beats), 64'(rdv_count));
    endtask

    // Waitrequest holds for the delay line length, then must drop soon after
    task automatic check_reset_release();
        int waited;
        for (int i = 0; i < N_WAITREQUEST_STAGES; i++)
        begin
            @(negedge mem_fiu);
            check_idle_outputs();
        end
        waited = 0;
        while (afu_waitrequest && waited < RELEASE_LIMIT)
        begin
            @(negedge mem_fiu);
            waited++;
        end
        assert (afu_waitrequest === 1'b0)
        else abort_run("afu_waitrequest did not fall after reset was released");
    endtask

    // Every read beat is compared with the oldest outstanding expectation
    always @(negedge mem_fiu)
    begin
        if (run_active && afu_readdatavalid)
        begin
            assert (exp_q.size() != 0)
            else abort_run("afu_readdatavalid arrived with no read outstanding");
            expected_word = exp_q.pop_front();
            assert (afu_readdata === expected_word)
            else value_error("afu_readdata", expected_word, afu_readdata);
            rdv_count++;
        end
    end

    initial
    begin
        #(TIMEOUT_NS);
        abort_run($sformatf("Watchdog expired after %0d ns before the test finished",
                            TIMEOUT_NS));
    end

    initial
    begin
        int        kind;
        int        beats;
        mem_addr_t addr;

        afu_address    = '0;
        afu_burstcount = mem_burst_t'(1);
        afu_writedata  = '0;
        afu_byteenable = '0;
        afu_read       = 1'b0;
        afu_write      = 1'b0;
        rst_n          = 1'b1;
        lcg_state      = LCG_SEED;
        exp_beats      = 0;
        rdv_count      = 0;
        stall_cycles   = 0;
        run_active     = 1'b0;

        @(negedge mem_fiu);
        rst_n = 1'b0;
        repeat (RESET_CYCLES)
        begin
            @(negedge mem_fiu);
            check_idle_outputs();
        end
        rst_n      = 1'b1;
        run_active = 1'b1;
        check_reset_release();

        // Single write, then a single read of the same word
        write_beat(10'h021, mem_burst_t'(1), 0, 64'h0123_4567_89ab_cdef, '1);
        read_burst(10'h021, 1);
        release_bus();
        wait_reads_done();

        // Partial byte enable over a known word gives a byte merge
        write_beat(10'h042, mem_burst_t'(1), 0, 64'hffee_ddcc_bbaa_9988, '1);
        write_beat(10'h042, mem_burst_t'(1), 0, 64'h1122_3344_5566_7788, 8'h5a);
        read_burst(10'h042, 1);
        release_bus();
        wait_reads_done();

        // Full length write burst read back as one burst
        write_burst(10'h080, MAX_BURST, 1'b1);
        read_burst(10'h080, MAX_BURST);
        release_bus();
        wait_reads_done();

        // Fill the random window so every later read hits written words
        for (int k = 0; k < RAND_WORDS / MAX_BURST; k++)
        begin
            write_burst(RAND_BASE + mem_addr_t'(k * MAX_BURST), MAX_BURST, 1'b1);
        end

        // Long read bursts back to back drain slower than they arrive
        for (int k = 0; k < RAND_WORDS / MAX_BURST; k++)
        begin
            read_burst(RAND_BASE + mem_addr_t'(k * MAX_BURST), MAX_BURST);
        end

        // Mixed traffic where kinds 0 and 2 write, kinds 1 and 3 read and 2 and 3 are bursts
        repeat (N_RANDOM_OPS)
        begin
            kind  = rand_below(4);
            beats = (kind >= 2) ? 1 + rand_below(MAX_BURST) : 1;
            addr  = RAND_BASE + mem_addr_t'(rand_below(RAND_WORDS - MAX_BURST + 1));
            if (kind % 2 == 0)
            begin
                write_burst(addr, beats, 1'b0);
            end
            else
            begin
                read_burst(addr, beats);
            end
        end
        release_bus();
        wait_reads_done();

        // A few quiet cycles let any stray beat show up in the checker
        repeat (4 * N_REG_STAGES + 8) @(negedge mem_fiu);
        assert (stall_cycles > 0)
        else abort_run("afu_waitrequest never pushed back during the traffic");

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== local_mem_subsystem.f ====
source/avalon_mem_pkg.sv
source/avalon_mem_reg_stage.sv
source/mem_req_fifo.sv
source/mem_burst_engine.sv
source/mem_bank_ram.sv
source/local_mem_subsystem.sv
sim/tb_local_mem_subsystem.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_local_mem_subsystem
FILELIST  ?= local_mem_subsystem.f
OBJDIR    ?= obj_dir
PASS_MSG  := RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
